// File: filelist.f
src/la_core_pkg.sv
src/la_regfile.sv
src/la_decode.sv
src/la_execute.sv
src/la_result.sv
src/la_core.sv
sim/la_core_asserts.sv
sim/la_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the la_core testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module la_core_tb \
    -f filelist.f -o la_core_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/la_core_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" "$log"; then
    exit 1
fi
if ! grep -q "TEST PASS" "$log"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

// File: sim/la_core_asserts.sv
module la_core_asserts (
    input logic                clk,
    input logic                reset,
    input logic                inst_valid,
    input la_core_pkg::trace_t trace
);

    // pipeline must be empty right after a reset edge
    assert property (@(posedge clk) reset |=> !trace.valid)
        else $error("trace.valid high in the cycle after reset");

    assert property (@(posedge clk) disable iff (reset) trace.rf_we |-> trace.valid)
        else $error("trace.rf_we high without trace.valid");

    // fixed latency of three cycles, both directions
    assert property (@(posedge clk) disable iff (reset) $past(inst_valid, 3) |-> trace.valid)
        else $error("accepted instruction did not retire three cycles later");

    assert property (@(posedge clk) disable iff (reset) trace.valid |-> $past(inst_valid, 3))
        else $error("retirement without an instruction accepted three cycles earlier");

    assert property (@(posedge clk) disable iff (reset) (trace.rf_wnum == '0) |-> !trace.rf_we)
        else $error("register write to r0 reported on the trace");

endmodule

bind la_core la_core_asserts u_asserts (
    .clk        (clk),
    .reset      (reset),
    .inst_valid (inst_valid),
    .trace      (trace)
);

// File: sim/la_core_tb.sv
module la_core_tb;

    typedef struct packed {
        logic [31:0] inst;
        logic        rf_we;
        logic [4:0]  rf_wnum;
        logic [31:0] rf_wdata;
        logic        burst;     // no idle cycles in front of this one
    } entry_t;

    typedef struct packed {
        logic [31:0] pc;
        logic        rf_we;
        logic [4:0]  rf_wnum;
        logic [31:0] rf_wdata;
        int          accept;    // cycle count when driven
    } expect_t;

    logic                clk;
    logic                reset;
    logic                inst_valid;
    logic [31:0]         inst;
    la_core_pkg::trace_t trace;

    entry_t      table_q[$];
    expect_t     pending_q[$];
    logic [31:0] lfsr;
    logic [31:0] pc_model;
    logic        in_reset_d = 1'b0;
    int          cycle = 0;
    int          errors = 0;

    la_core dut_i (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .trace      (trace)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // right shifting galois lfsr stepped once per bit taken
    function automatic logic lfsr_take();
        logic b;
        b = lfsr[0];
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        return b;
    endfunction

    function automatic logic [31:0] enc_r3(input logic [16:0] op, input int rd, input int rj,
                                           input int rk);
        return {op, rk[4:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] enc_ri12(input logic [9:0] op, input int rd, input int rj,
                                             input logic [11:0] imm);
        return {op, imm, rj[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] enc_ri20(input logic [6:0] op, input int rd,
                                             input logic [19:0] imm);
        return {op, imm, rd[4:0]};
    endfunction

    task automatic add_entry(input logic [31:0] word, input int we, input int wnum,
                             input logic [31:0] value, input int burst);
        entry_t e;
        e.inst     = word;
        e.rf_we    = (we != 0);
        e.rf_wnum  = wnum[4:0];
        e.rf_wdata = value;
        e.burst    = (burst != 0);
        table_q.push_back(e);
    endtask

    task automatic build_table();
        // constants from lu12i.w and ori
        add_entry(enc_ri20(la_core_pkg::OP7_LU12I_W, 1, 20'h12345), 1, 1, 32'h1234_5000, 0);
        add_entry(enc_ri12(la_core_pkg::OP10_ORI, 1, 1, 12'h678), 1, 1, 32'h1234_5678, 1);
        add_entry(enc_ri20(la_core_pkg::OP7_LU12I_W, 2, 20'h80000), 1, 2, 32'h8000_0000, 0);
        add_entry(enc_ri12(la_core_pkg::OP10_ORI, 2, 2, 12'hfff), 1, 2, 32'h8000_0fff, 1);
        add_entry(enc_ri12(la_core_pkg::OP10_ADDI_W, 3, 0, 12'hfff), 1, 3, 32'hffff_ffff, 0);
        add_entry(enc_ri12(la_core_pkg::OP10_ADDI_W, 4, 0, 12'h7ff), 1, 4, 32'h0000_07ff, 0);
        // three-register alu ops
        add_entry(enc_r3(la_core_pkg::OP17_ADD_W, 5, 1, 2), 1, 5, 32'h9234_6677, 0);
        add_entry(enc_r3(la_core_pkg::OP17_SUB_W, 6, 1, 2), 1, 6, 32'h9234_4679, 0);
        add_entry(enc_r3(la_core_pkg::OP17_SLT, 7, 2, 1), 1, 7, 32'h0000_0001, 0);
        add_entry(enc_r3(la_core_pkg::OP17_SLTU, 8, 2, 1), 1, 8, 32'h0000_0000, 0);
        add_entry(enc_r3(la_core_pkg::OP17_SLTU, 10, 1, 3), 1, 10, 32'h0000_0001, 0);
        add_entry(enc_r3(la_core_pkg::OP17_AND, 11, 1, 2), 1, 11, 32'h0000_0678, 0);
        add_entry(enc_r3(la_core_pkg::OP17_OR, 12, 1, 2), 1, 12, 32'h9234_5fff, 0);
        add_entry(enc_r3(la_core_pkg::OP17_XOR, 13, 1, 2), 1, 13, 32'h9234_5987, 0);
        add_entry(enc_ri12(la_core_pkg::OP10_ADDI_W, 14, 0, 12'h01f), 1, 14, 32'h0000_001f, 0);
        add_entry(enc_r3(la_core_pkg::OP17_SLL_W, 15, 3, 14), 1, 15, 32'h8000_0000, 0);
        add_entry(enc_r3(la_core_pkg::OP17_SRL_W, 16, 2, 14), 1, 16, 32'h0000_0001, 0);
        add_entry(enc_r3(la_core_pkg::OP17_SRA_W, 17, 2, 14), 1, 17, 32'hffff_ffff, 0);
        add_entry(enc_ri12(la_core_pkg::OP10_ADDI_W, 19, 0, 12'h024), 1, 19, 32'h0000_0024, 0);
        add_entry(enc_r3(la_core_pkg::OP17_SLL_W, 20, 1, 19), 1, 20, 32'h2345_6780, 0);
        add_entry(enc_r3(la_core_pkg::OP17_SRA_W, 21, 2, 19), 1, 21, 32'hf800_00ff, 0);
        // dependent chain at distances 1 to 3
        add_entry(enc_ri12(la_core_pkg::OP10_ADDI_W, 22, 0, 12'h005), 1, 22, 32'h0000_0005, 0);
        add_entry(enc_ri12(la_core_pkg::OP10_ADDI_W, 22, 22, 12'h003), 1, 22, 32'h0000_0008, 1);
        add_entry(enc_ri12(la_core_pkg::OP10_ADDI_W, 23, 22, 12'h001), 1, 23, 32'h0000_0009, 1);
        add_entry(enc_r3(la_core_pkg::OP17_ADD_W, 24, 22, 23), 1, 24, 32'h0000_0011, 1);
        add_entry(enc_r3(la_core_pkg::OP17_ADD_W, 25, 22, 24), 1, 25, 32'h0000_0019, 1);
        add_entry(enc_r3(la_core_pkg::OP17_SUB_W, 26, 25, 24), 1, 26, 32'h0000_0008, 1);
        add_entry(enc_ri12(la_core_pkg::OP10_ADDI_W, 1, 0, 12'h001), 1, 1, 32'h0000_0001, 0);
        add_entry(enc_ri12(la_core_pkg::OP10_ADDI_W, 1, 0, 12'h002), 1, 1, 32'h0000_0002, 1);
        add_entry(enc_r3(la_core_pkg::OP17_ADD_W, 27, 1, 1), 1, 27, 32'h0000_0004, 1);
        // r0 stays zero and unknown opcodes write nothing
        add_entry(enc_ri12(la_core_pkg::OP10_ADDI_W, 0, 0, 12'h123), 0, 0, 32'h0, 0);
        add_entry(enc_r3(la_core_pkg::OP17_ADD_W, 28, 0, 0), 1, 28, 32'h0000_0000, 1);
        add_entry(enc_ri20(la_core_pkg::OP7_LU12I_W, 0, 20'habcde), 0, 0, 32'h0, 1);
        add_entry(enc_r3(la_core_pkg::OP17_OR, 29, 0, 1), 1, 29, 32'h0000_0002, 1);
        add_entry(32'h0000_0005, 0, 0, 32'h0, 0);
        add_entry(32'hffff_ffff, 0, 0, 32'h0, 1);
        add_entry(enc_r3(la_core_pkg::OP17_OR, 30, 5, 0), 1, 30, 32'h9234_6677, 1);
        // zero and sign extension of immediates
        add_entry(enc_ri12(la_core_pkg::OP10_XORI, 31, 3, 12'h800), 1, 31, 32'hffff_f7ff, 0);
        add_entry(enc_ri12(la_core_pkg::OP10_ANDI, 30, 3, 12'h8f0), 1, 30, 32'h0000_08f0, 1);
        add_entry(enc_ri12(la_core_pkg::OP10_SLTI, 29, 3, 12'h000), 1, 29, 32'h0000_0001, 0);
        add_entry(enc_ri20(la_core_pkg::OP7_LU12I_W, 20, 20'hfffff), 1, 20, 32'hffff_f000, 0);
        add_entry(enc_ri12(la_core_pkg::OP10_ORI, 20, 20, 12'h001), 1, 20, 32'hffff_f001, 1);
        add_entry(enc_r3(la_core_pkg::OP17_OR, 9, 31, 0), 1, 9, 32'hffff_f7ff, 0);
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        assert (got === want)
        else begin
            $display("Mismatch %s: got %h, expected %h", name, got, want);
            errors++;
        end
    endtask

    task automatic apply_entry(input entry_t e);
        int      gap;
        expect_t x;
        gap = 0;
        if (!e.burst) begin
            gap = lfsr_take() ? 2 : 0;
            gap = gap + (lfsr_take() ? 1 : 0);
        end
        repeat (gap) begin
            @(negedge clk);
            inst_valid = 1'b0;
        end
        @(negedge clk);
        inst_valid = 1'b1;
        inst       = e.inst;
        x.pc       = pc_model;
        x.rf_we    = e.rf_we;
        x.rf_wnum  = e.rf_wnum;
        x.rf_wdata = e.rf_wdata;
        x.accept   = cycle;
        pending_q.push_back(x);
        pc_model   = pc_model + 32'd4;
    endtask

    // trace sampled at the rising edge before the pipeline moves
    always @(posedge clk) begin
        expect_t x;
        cycle      <= cycle + 1;
        in_reset_d <= reset;
        if (in_reset_d) begin
            assert (trace.valid === 1'b0)
            else begin
                $display("trace.valid went high during or just after reset");
                errors++;
            end
        end else if (trace.valid === 1'b1) begin
            assert (pending_q.size() != 0)
            else begin
                $display("retirement at pc %h with no instruction outstanding", trace.pc);
                errors++;
            end
            if (pending_q.size() != 0) begin
                x = pending_q.pop_front();
                compare_field("pc", trace.pc, x.pc);
                compare_field("rf_we", {31'b0, trace.rf_we}, {31'b0, x.rf_we});
                if (x.rf_we) begin
                    compare_field("rf_wnum", {27'b0, trace.rf_wnum}, {27'b0, x.rf_wnum});
                    compare_field("rf_wdata", trace.rf_wdata, x.rf_wdata);
                end
                assert (cycle == x.accept + 3)
                else begin
                    $display("pc %h retired %0d cycles after acceptance instead of 3",
                             x.pc, cycle - x.accept);
                    errors++;
                end
            end
        end
    end

    initial begin
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = 32'h0;
        lfsr       = 32'ha94;
        pc_model   = 32'h1c00_0000; // loongarch reset vector
        build_table();
        repeat (2) @(negedge clk);
        reset = 1'b0;
        foreach (table_q[i]) begin
            apply_entry(table_q[i]);
        end
        @(negedge clk);
        inst_valid = 1'b0;
        while (pending_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk); // room for stray retirements
        $display("errors: %0d, instructions applied: %0d", errors, table_q.size());
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // watchdog allows five cycles per entry plus reset and drain
    initial begin
        #1;
        repeat (table_q.size() * 5 + 20) @(posedge clk);
        $display("timeout: %0d instructions never retired, errors: %0d",
                 pending_q.size(), errors);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: src/la_core.sv
module la_core (
    input  logic                clk,
    input  logic                reset,
    input  logic                inst_valid,
    input  logic [31:0]         inst,
    output la_core_pkg::trace_t trace
);

    logic [la_core_pkg::REG_ADDR_W-1:0] rf_raddr1;
    logic [la_core_pkg::REG_ADDR_W-1:0] rf_raddr2;
    logic [la_core_pkg::XLEN-1:0]       rf_rdata1;
    logic [la_core_pkg::XLEN-1:0]       rf_rdata2;
    la_core_pkg::dec_to_ex_t            dec_item;
    la_core_pkg::ex_to_res_t            ex_item;
    la_core_pkg::ex_to_res_t            res_item;
    logic [la_core_pkg::XLEN-1:0]       ex_value;

    la_decode u_decode (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (la_core_pkg::inst_t'(inst)),
        .rf_rdata1  (rf_rdata1),
        .rf_rdata2  (rf_rdata2),
        .ex_item    (ex_item),
        .res_item   (res_item),
        .ex_value   (ex_value),
        .rf_raddr1  (rf_raddr1),
        .rf_raddr2  (rf_raddr2),
        .dec_item   (dec_item)
    );

    la_execute u_execute (
        .clk      (clk),
        .reset    (reset),
        .dec_item (dec_item),
        .ex_item  (ex_item),
        .ex_value (ex_value)
    );

    la_result u_result (
        .clk      (clk),
        .reset    (reset),
        .ex_item  (ex_item),
        .res_item (res_item),
        .trace    (trace)
    );

    la_regfile u_regfile (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (res_item.valid & res_item.rf_we),
        .waddr  (res_item.rd),
        .wdata  (res_item.value)
    );

endmodule

// File: src/la_core_pkg.sv
package la_core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h1c00_0000;
    localparam logic [XLEN-1:0] PC_STEP  = 32'd4;

    // three-register forms, matched on inst[31:15]
    localparam logic [16:0] OP17_ADD_W = 17'h00020;
    localparam logic [16:0] OP17_SUB_W = 17'h00022;
    localparam logic [16:0] OP17_SLT   = 17'h00024;
    localparam logic [16:0] OP17_SLTU  = 17'h00025;
    localparam logic [16:0] OP17_AND   = 17'h00029;
    localparam logic [16:0] OP17_OR    = 17'h0002a;
    localparam logic [16:0] OP17_XOR   = 17'h0002b;
    localparam logic [16:0] OP17_SLL_W = 17'h0002e;
    localparam logic [16:0] OP17_SRL_W = 17'h0002f;
    localparam logic [16:0] OP17_SRA_W = 17'h00030;

    // 12-bit immediate forms, inst[31:22]
    localparam logic [9:0] OP10_SLTI   = 10'h008;
    localparam logic [9:0] OP10_ADDI_W = 10'h00a;
    localparam logic [9:0] OP10_ANDI   = 10'h00d;
    localparam logic [9:0] OP10_ORI    = 10'h00e;
    localparam logic [9:0] OP10_XORI   = 10'h00f;

    localparam logic [6:0] OP7_LU12I_W = 7'h0a; // inst[31:25]

    typedef struct packed {
        logic [16:0]           op17;
        logic [REG_ADDR_W-1:0] rk;
        logic [REG_ADDR_W-1:0] rj;
        logic [REG_ADDR_W-1:0] rd;
    } r3_fmt_t;

    typedef struct packed {
        logic [9:0]            op10;
        logic [11:0]           imm12;
        logic [REG_ADDR_W-1:0] rj;
        logic [REG_ADDR_W-1:0] rd;
    } ri12_fmt_t;

    typedef struct packed {
        logic [6:0]            op7;
        logic [19:0]           imm20;
        logic [REG_ADDR_W-1:0] rd;
    } ri20_fmt_t;

    // same 32-bit word, three field layouts
    typedef union packed {
        r3_fmt_t   r3;
        ri12_fmt_t ri12;
        ri20_fmt_t ri20;
    } inst_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_or,
        alu_xor, alu_sll, alu_srl, alu_sra, alu_pass2
    } alu_op_e;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        alu_op_e               op;
        logic [XLEN-1:0]       src1;
        logic [XLEN-1:0]       src2;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rf_we;
    } dec_to_ex_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rf_we;
        logic [XLEN-1:0]       value;
    } ex_to_res_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic                  rf_we;
        logic [REG_ADDR_W-1:0] rf_wnum;
        logic [XLEN-1:0]       rf_wdata;
    } trace_t;

endpackage

// File: src/la_decode.sv
module la_decode (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               inst_valid,
    input  la_core_pkg::inst_t                 inst,
    input  logic [la_core_pkg::XLEN-1:0]       rf_rdata1,
    input  logic [la_core_pkg::XLEN-1:0]       rf_rdata2,
    input  la_core_pkg::ex_to_res_t            ex_item,
    input  la_core_pkg::ex_to_res_t            res_item,
    input  logic [la_core_pkg::XLEN-1:0]       ex_value,
    output logic [la_core_pkg::REG_ADDR_W-1:0] rf_raddr1,
    output logic [la_core_pkg::REG_ADDR_W-1:0] rf_raddr2,
    output la_core_pkg::dec_to_ex_t            dec_item
);

    logic [la_core_pkg::XLEN-1:0] pc;
    la_core_pkg::alu_op_e         op;
    logic                         legal;
    logic                         use_imm;
    logic [la_core_pkg::XLEN-1:0] imm;
    logic [la_core_pkg::XLEN-1:0] imm12_sext;
    logic [la_core_pkg::XLEN-1:0] imm12_zext;
    logic [la_core_pkg::XLEN-1:0] rj_val;
    logic [la_core_pkg::XLEN-1:0] rk_val;
    la_core_pkg::dec_to_ex_t      dec_d;

    // older item writes the register this source reads
    function automatic logic hit(
        input logic                               valid,
        input logic                               we,
        input logic [la_core_pkg::REG_ADDR_W-1:0] rd,
        input logic [la_core_pkg::REG_ADDR_W-1:0] src
    );
        return valid && we && (rd == src);
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= la_core_pkg::RESET_PC;
        end else if (inst_valid) begin
            pc <= pc + la_core_pkg::PC_STEP;
        end
    end

    assign rf_raddr1 = inst.r3.rj;
    assign rf_raddr2 = inst.r3.rk;

    assign imm12_sext = {{20{inst.ri12.imm12[11]}}, inst.ri12.imm12};
    assign imm12_zext = {20'b0, inst.ri12.imm12};

    always_comb begin
        op      = la_core_pkg::alu_add;
        legal   = 1'b0;
        use_imm = 1'b0;
        imm     = '0;

        case (inst.r3.op17)
            la_core_pkg::OP17_ADD_W: begin op = la_core_pkg::alu_add;  legal = 1'b1; end
            la_core_pkg::OP17_SUB_W: begin op = la_core_pkg::alu_sub;  legal = 1'b1; end
            la_core_pkg::OP17_SLT:   begin op = la_core_pkg::alu_slt;  legal = 1'b1; end
            la_core_pkg::OP17_SLTU:  begin op = la_core_pkg::alu_sltu; legal = 1'b1; end
            la_core_pkg::OP17_AND:   begin op = la_core_pkg::alu_and;  legal = 1'b1; end
            la_core_pkg::OP17_OR:    begin op = la_core_pkg::alu_or;   legal = 1'b1; end
            la_core_pkg::OP17_XOR:   begin op = la_core_pkg::alu_xor;  legal = 1'b1; end
            la_core_pkg::OP17_SLL_W: begin op = la_core_pkg::alu_sll;  legal = 1'b1; end
            la_core_pkg::OP17_SRL_W: begin op = la_core_pkg::alu_srl;  legal = 1'b1; end
            la_core_pkg::OP17_SRA_W: begin op = la_core_pkg::alu_sra;  legal = 1'b1; end
            default: ;
        endcase

        // opcode spaces of the three views do not overlap
        case (inst.ri12.op10)
            la_core_pkg::OP10_ADDI_W: begin
                op = la_core_pkg::alu_add;
                imm = imm12_sext;
                {legal, use_imm} = 2'b11;
            end
            la_core_pkg::OP10_SLTI: begin
                op = la_core_pkg::alu_slt;
                imm = imm12_sext;
                {legal, use_imm} = 2'b11;
            end
            la_core_pkg::OP10_ANDI: begin
                op = la_core_pkg::alu_and;
                imm = imm12_zext;
                {legal, use_imm} = 2'b11;
            end
            la_core_pkg::OP10_ORI: begin
                op = la_core_pkg::alu_or;
                imm = imm12_zext;
                {legal, use_imm} = 2'b11;
            end
            la_core_pkg::OP10_XORI: begin
                op = la_core_pkg::alu_xor;
                imm = imm12_zext;
                {legal, use_imm} = 2'b11;
            end
            default: ;
        endcase

        if (inst.ri20.op7 == la_core_pkg::OP7_LU12I_W) begin
            op = la_core_pkg::alu_pass2;
            imm = {inst.ri20.imm20, 12'b0};
            {legal, use_imm} = 2'b11;
        end
    end

    // youngest producer first: execute, then its register, then result
    assign rj_val = hit(dec_item.valid, dec_item.rf_we, dec_item.rd, inst.r3.rj) ? ex_value :
                    hit(ex_item.valid, ex_item.rf_we, ex_item.rd, inst.r3.rj) ? ex_item.value :
                    hit(res_item.valid, res_item.rf_we, res_item.rd, inst.r3.rj) ?
                        res_item.value : rf_rdata1;
    assign rk_val = hit(dec_item.valid, dec_item.rf_we, dec_item.rd, inst.r3.rk) ? ex_value :
                    hit(ex_item.valid, ex_item.rf_we, ex_item.rd, inst.r3.rk) ? ex_item.value :
                    hit(res_item.valid, res_item.rf_we, res_item.rd, inst.r3.rk) ?
                        res_item.value : rf_rdata2;

    always_comb begin
        dec_d.valid = inst_valid;
        dec_d.pc    = pc;
        dec_d.op    = op;
        dec_d.src1  = rj_val;
        dec_d.src2  = use_imm ? imm : rk_val;
        dec_d.rd    = inst.r3.rd;
        dec_d.rf_we = inst_valid && legal && (inst.r3.rd != '0); // illegal retires silently
    end

    always_ff @(posedge clk) begin
        dec_item <= dec_d;
        if (reset) begin
            dec_item.valid <= 1'b0;
            dec_item.rf_we <= 1'b0;
        end
    end

endmodule

// File: src/la_execute.sv
module la_execute (
    input  logic                         clk,
    input  logic                         reset,
    input  la_core_pkg::dec_to_ex_t      dec_item,
    output la_core_pkg::ex_to_res_t      ex_item,
    output logic [la_core_pkg::XLEN-1:0] ex_value
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = dec_item.src2[4:0]; // only the low five bits count
    assign lt_signed   = $signed(dec_item.src1) < $signed(dec_item.src2);
    assign lt_unsigned = dec_item.src1 < dec_item.src2;

    always_comb begin
        case (dec_item.op)
            la_core_pkg::alu_add:  ex_value = dec_item.src1 + dec_item.src2;
            la_core_pkg::alu_sub:  ex_value = dec_item.src1 - dec_item.src2;
            la_core_pkg::alu_slt:  ex_value = {31'b0, lt_signed};
            la_core_pkg::alu_sltu: ex_value = {31'b0, lt_unsigned};
            la_core_pkg::alu_and:  ex_value = dec_item.src1 & dec_item.src2;
            la_core_pkg::alu_or:   ex_value = dec_item.src1 | dec_item.src2;
            la_core_pkg::alu_xor:  ex_value = dec_item.src1 ^ dec_item.src2;
            la_core_pkg::alu_sll:  ex_value = dec_item.src1 << shamt;
            la_core_pkg::alu_srl:  ex_value = dec_item.src1 >> shamt;
            la_core_pkg::alu_sra:  ex_value = $unsigned($signed(dec_item.src1) >>> shamt);
            default:               ex_value = dec_item.src2; // pass2 for lu12i.w
        endcase
    end

    always_ff @(posedge clk) begin
        ex_item <= '{
            valid: dec_item.valid,
            pc:    dec_item.pc,
            rd:    dec_item.rd,
            rf_we: dec_item.rf_we,
            value: ex_value
        };
        if (reset) begin
            ex_item.valid <= 1'b0;
            ex_item.rf_we <= 1'b0;
        end
    end

endmodule

// File: src/la_regfile.sv
module la_regfile (
    input  logic                               clk,
    input  logic [la_core_pkg::REG_ADDR_W-1:0] raddr1,
    input  logic [la_core_pkg::REG_ADDR_W-1:0] raddr2,
    output logic [la_core_pkg::XLEN-1:0]       rdata1,
    output logic [la_core_pkg::XLEN-1:0]       rdata2,
    input  logic                               we,
    input  logic [la_core_pkg::REG_ADDR_W-1:0] waddr,
    input  logic [la_core_pkg::XLEN-1:0]       wdata
);

    localparam int NUM_REGS = 1 << la_core_pkg::REG_ADDR_W;

    logic [la_core_pkg::XLEN-1:0] regs [0:NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired to zero on the read side
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: src/la_result.sv
module la_result (
    input  logic                    clk,
    input  logic                    reset,
    input  la_core_pkg::ex_to_res_t ex_item,
    output la_core_pkg::ex_to_res_t res_item,
    output la_core_pkg::trace_t     trace
);

    // retiring item that also feeds the register file write
    always_ff @(posedge clk) begin
        res_item <= ex_item;
        if (reset) begin
            res_item.valid <= 1'b0;
            res_item.rf_we <= 1'b0;
        end
    end

    always_comb begin
        trace.valid    = res_item.valid;
        trace.pc       = res_item.pc;
        trace.rf_we    = res_item.rf_we;
        trace.rf_wnum  = res_item.rd;
        trace.rf_wdata = res_item.value;
    end

endmodule
